// ==== dv/tb_disk_bridge.sv ====
// Table-driven testbench for the disk block bridge; compile with the RTL via vlog.f
`default_nettype none

module tb_disk_bridge;

	localparam int RESET_CYCLES    = 10;
	localparam int STROBE_HOLD     = 4;
	localparam int WAIT_LIMIT      = 40;
	localparam int ROW_BUDGET      = 200;
	localparam int NUM_ROWS        = 13;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * ROW_BUDGET;

	localparam logic [3:0] OP_LBA     = 4'd0;
	localparam logic [3:0] OP_HOST_WR = 4'd1;
	localparam logic [3:0] OP_HOST_RD = 4'd2;
	localparam logic [3:0] OP_BLK_RD  = 4'd3;
	localparam logic [3:0] OP_BLK_WR  = 4'd4;
	localparam logic [3:0] OP_MOUNT   = 4'd5;
	localparam logic [3:0] OP_SD_WR   = 4'd6;
	localparam logic [3:0] OP_SD_RD   = 4'd7;

	// arg is {readonly, type} for mounts; value is LBA, byte count or size
	typedef struct packed {
		logic [3:0]  kind;
		logic [2:0]  slot;
		logic [2:0]  arg;
		logic [31:0] value;
		logic [31:0] exp_val;
	} row_t;

	logic clk_sys = 1'b0;
	logic areset;

	logic [5:0]                  host_ctrl_i;
	disk_bridge_pkg::host_data_u host_wdata_i;
	logic                        host_data_wr_i;
	logic                        host_data_rd_i;
	logic                        host_io_wr_i;
	logic [31:0]                 host_rdata_o;
	logic [7:0]                  host_status_o;
	logic [7:0]                  sd_rd_o;
	logic [7:0]                  sd_wr_o;
	logic [7:0]                  sd_ack_i;
	logic [31:0]                 sd_lba_o;
	logic [8:0]                  sd_buff_addr_i;
	logic [7:0]                  sd_buff_dout_i;
	logic                        sd_buff_wr_i;
	logic [7:0]                  sd_buff_din_o;
	logic [7:0]                  img_mounted_i;
	logic                        img_readonly_i;
	logic [31:0]                 img_size_i;
	logic [1:0]                  img_type_i;

	row_t       rows [NUM_ROWS];
	logic [7:0] host_bytes [$];
	logic [7:0] sd_bytes [$];
	logic [15:0] lfsr_state = 16'd5;
	logic       mounted_model = 1'b0;
	int         checks = 0;
	int         errors = 0;
	int         timeouts = 0;

	always #5 clk_sys = ~clk_sys;

	disk_bridge_top u_disk_bridge_top (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.host_ctrl_i    (host_ctrl_i),
		.host_wdata_i   (host_wdata_i),
		.host_data_wr_i (host_data_wr_i),
		.host_data_rd_i (host_data_rd_i),
		.host_io_wr_i   (host_io_wr_i),
		.host_rdata_o   (host_rdata_o),
		.host_status_o  (host_status_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.sd_ack_i       (sd_ack_i),
		.sd_lba_o       (sd_lba_o),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.sd_buff_din_o  (sd_buff_din_o),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i)
	);

	// ========================================================================
	// Helpers
	// ========================================================================
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// One LFSR step per data bit
	task automatic random_byte(output logic [7:0] b);
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at time %0t: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic hold_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic pulse_data_wr();
		host_data_wr_i = 1'b1;
		hold_cycles(STROBE_HOLD);
		host_data_wr_i = 1'b0;
		hold_cycles(STROBE_HOLD);
	endtask

	task automatic pulse_data_rd();
		host_data_rd_i = 1'b1;
		hold_cycles(STROBE_HOLD);
		host_data_rd_i = 1'b0;
		hold_cycles(STROBE_HOLD);
	endtask

	task automatic pulse_io_wr();
		host_io_wr_i = 1'b1;
		hold_cycles(STROBE_HOLD);
		host_io_wr_i = 1'b0;
		hold_cycles(STROBE_HOLD);
	endtask

	// ========================================================================
	// Operations
	// ========================================================================
	task automatic write_lba(input logic [31:0] lba, input logic [31:0] exp_lba);
		host_ctrl_i = 6'b000001;
		host_wdata_i.lba = lba;
		pulse_data_wr();
		check_value("sd_lba_o", exp_lba, sd_lba_o);
		host_ctrl_i = 6'b000000;
	endtask

	task automatic host_write_bytes(input int count);
		logic [7:0] b;
		host_ctrl_i = 6'b000000;
		pulse_io_wr();
		host_bytes.delete();
		for (int k = 0; k < count; k++) begin
			random_byte(b);
			host_bytes.push_back(b);
			host_wdata_i.byte_view.unused = '0;
			host_wdata_i.byte_view.data = b;
			pulse_data_wr();
		end
	endtask

	task automatic host_read_bytes(input int count);
		host_ctrl_i = 6'b000000;
		pulse_io_wr();
		for (int k = 0; k < count; k++) begin
			check_value("host_rdata_o", 32'(sd_bytes[k]), host_rdata_o);
			pulse_data_rd();
		end
	endtask

	task automatic sd_write_bytes(input int count);
		logic [7:0] b;
		sd_bytes.delete();
		for (int k = 0; k < count; k++) begin
			random_byte(b);
			sd_bytes.push_back(b);
			sd_buff_addr_i = 9'(k);
			sd_buff_dout_i = b;
			sd_buff_wr_i = 1'b1;
			@(negedge clk_sys);
		end
		sd_buff_wr_i = 1'b0;
	endtask

	// Read data lags its address by one cycle
	task automatic sd_read_bytes(input int count);
		for (int k = 0; k < count; k++) begin
			sd_buff_addr_i = 9'(k);
			@(negedge clk_sys);
			check_value("sd_buff_din_o", 32'(host_bytes[k]), 32'(sd_buff_din_o));
		end
	endtask

	task automatic request_block(input logic is_write, input logic [2:0] slot,
			input logic [7:0] exp_req);
		logic [5:0] ctrl;
		int n;
		ctrl = '0;
		ctrl[disk_bridge_pkg::CTRL_SLOT_LSB +: 3] = slot;
		ctrl[is_write ? disk_bridge_pkg::CTRL_BLK_WR : disk_bridge_pkg::CTRL_BLK_RD] = 1'b1;
		host_ctrl_i = ctrl;
		n = 0;
		while (((sd_rd_o | sd_wr_o) == 8'h00) && (n < WAIT_LIMIT)) begin
			@(negedge clk_sys);
			n++;
		end
		if (n == WAIT_LIMIT) begin
			timeouts++;
			$display("Timeout: no SD request was raised for slot %0d", slot);
		end
		check_value("sd_rd_o", 32'(is_write ? 8'h00 : exp_req), 32'(sd_rd_o));
		check_value("sd_wr_o", 32'(is_write ? exp_req : 8'h00), 32'(sd_wr_o));
		check_value("io_done", 32'd0, 32'(host_status_o[disk_bridge_pkg::STAT_IO_DONE]));
		n = 0;
		while (!host_status_o[disk_bridge_pkg::STAT_IO_DONE] && (n < WAIT_LIMIT)) begin
			@(negedge clk_sys);
			n++;
		end
		if (n == WAIT_LIMIT) begin
			timeouts++;
			$display("Timeout: io_done never set after the slot %0d request", slot);
		end
		check_value("sd_rd_o", 32'd0, 32'(sd_rd_o));
		check_value("sd_wr_o", 32'd0, 32'(sd_wr_o));
		check_value("io_done", 32'd1, 32'(host_status_o[disk_bridge_pkg::STAT_IO_DONE]));
		host_ctrl_i = 6'b000000;
		hold_cycles(STROBE_HOLD);
	endtask

	task automatic mount_image(input logic [2:0] slot, input logic [2:0] arg,
			input logic [31:0] size, input logic exp_ro);
		img_readonly_i = arg[2];
		img_type_i = arg[1:0];
		img_size_i = size;
		img_mounted_i = 8'h01 << slot;
		hold_cycles(STROBE_HOLD);
		img_mounted_i = 8'h00;
		hold_cycles(STROBE_HOLD);
		mounted_model = ~mounted_model;
		check_value("fileno", 32'(slot),
			32'(host_status_o[disk_bridge_pkg::STAT_FILENO +: 3]));
		check_value("ftype", 32'(arg[1:0]),
			32'(host_status_o[disk_bridge_pkg::STAT_FTYPE +: 2]));
		check_value("readonly", 32'(exp_ro), 32'(host_status_o[disk_bridge_pkg::STAT_RO]));
		check_value("mounted", 32'(mounted_model),
			32'(host_status_o[disk_bridge_pkg::STAT_MOUNTED]));
		host_ctrl_i = 6'b000001;
		hold_cycles(2);
		check_value("host_rdata_o", size, host_rdata_o);
		host_ctrl_i = 6'b000000;
		hold_cycles(2);
	endtask

	task automatic fill_table();
		rows[0]  = '{OP_LBA,     3'd0, 3'd0, 32'h0001_2345, 32'h0001_2345};
		rows[1]  = '{OP_BLK_RD,  3'd2, 3'd0, 32'h0,         32'h0000_0004};
		rows[2]  = '{OP_LBA,     3'd0, 3'd0, 32'h00AB_CDEF, 32'h00AB_CDEF};
		rows[3]  = '{OP_BLK_WR,  3'd6, 3'd0, 32'h0,         32'h0000_0040};
		rows[4]  = '{OP_HOST_WR, 3'd0, 3'd0, 32'd8,         32'h0};
		rows[5]  = '{OP_SD_RD,   3'd0, 3'd0, 32'd8,         32'h0};
		rows[6]  = '{OP_SD_WR,   3'd0, 3'd0, 32'd6,         32'h0};
		rows[7]  = '{OP_HOST_RD, 3'd0, 3'd0, 32'd6,         32'h0};
		rows[8]  = '{OP_MOUNT,   3'd1, 3'b010, 32'h0002_D000, 32'd0};
		rows[9]  = '{OP_MOUNT,   3'd4, 3'b001, 32'h0000_4000, 32'd1};
		rows[10] = '{OP_MOUNT,   3'd3, 3'b111, 32'h0001_6800, 32'd1};
		rows[11] = '{OP_BLK_RD,  3'd5, 3'd0, 32'h0,         32'h0000_0020};
		rows[12] = '{OP_MOUNT,   3'd5, 3'b000, 32'h0000_2000, 32'd1};
	endtask

	// ========================================================================
	// Image server model acks the pending request after a slot-dependent wait
	// ========================================================================
	initial begin
		logic [7:0] req;
		sd_ack_i = 8'h00;
		forever begin
			@(negedge clk_sys);
			if ((sd_rd_o | sd_wr_o) != 8'h00) begin
				req = sd_rd_o | sd_wr_o;
				hold_cycles(3 + int'(host_ctrl_i[disk_bridge_pkg::CTRL_SLOT_LSB +: 3]));
				sd_ack_i = req;
				hold_cycles(3);
				sd_ack_i = 8'h00;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog: simulation ran past its cycle limit");
		$display("Checks run: %0d, value errors: %0d, timeouts: %0d",
			checks, errors, timeouts);
		$display("test failed");
		$finish;
	end

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		areset = 1'b1;
		host_ctrl_i = '0;
		host_wdata_i = '0;
		host_data_wr_i = 1'b0;
		host_data_rd_i = 1'b0;
		host_io_wr_i = 1'b0;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i = 1'b0;
		img_mounted_i = '0;
		img_readonly_i = 1'b0;
		img_size_i = '0;
		img_type_i = '0;
		fill_table();

		repeat (RESET_CYCLES) @(negedge clk_sys);
		areset = 1'b0;
		@(negedge clk_sys);
		check_value("sd_rd_o", 32'd0, 32'(sd_rd_o));
		check_value("sd_wr_o", 32'd0, 32'(sd_wr_o));
		check_value("io_done", 32'd0, 32'(host_status_o[disk_bridge_pkg::STAT_IO_DONE]));
		check_value("mounted", 32'd0, 32'(host_status_o[disk_bridge_pkg::STAT_MOUNTED]));

		for (int r = 0; r < NUM_ROWS; r++) begin
			case (rows[r].kind)
				OP_LBA:     write_lba(rows[r].value, rows[r].exp_val);
				OP_HOST_WR: host_write_bytes(int'(rows[r].value));
				OP_HOST_RD: host_read_bytes(int'(rows[r].value));
				OP_BLK_RD:  request_block(1'b0, rows[r].slot, rows[r].exp_val[7:0]);
				OP_BLK_WR:  request_block(1'b1, rows[r].slot, rows[r].exp_val[7:0]);
				OP_MOUNT:   mount_image(rows[r].slot, rows[r].arg, rows[r].value,
					rows[r].exp_val[0]);
				OP_SD_WR:   sd_write_bytes(int'(rows[r].value));
				OP_SD_RD:   sd_read_bytes(int'(rows[r].value));
				default: begin
					errors++;
					$display("Table row %0d has an unknown operation kind", r);
				end
			endcase
		end

		$display("Checks run: %0d, value errors: %0d, timeouts: %0d",
			checks, errors, timeouts);
		if ((errors == 0) && (timeouts == 0)) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in sim.log
verilator --binary --timing --assert --top-module tb_disk_bridge -f vlog.f \
	--Mdir obj_dir -o sim_disk_bridge > build.log 2>&1 \
	&& ./obj_dir/sim_disk_bridge > sim.log 2>&1 \
	; grep -qx "test passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL (see build.log and sim.log)"; exit 1; }

// ==== source/block_request.sv ====
// Per-slot SD block requests, acknowledge tracking and the host I/O-done flag
`default_nettype none

module block_request (
	input  logic                                  clk_sys,
	input  logic                                  areset,

	input  logic                                  blk_rd_i,
	input  logic                                  blk_wr_i,
	input  logic [disk_bridge_pkg::SLOT_W-1:0]    slot_i,

	input  logic [disk_bridge_pkg::NUM_SLOTS-1:0] sd_ack_i,
	output logic [disk_bridge_pkg::NUM_SLOTS-1:0] sd_rd_o,
	output logic [disk_bridge_pkg::NUM_SLOTS-1:0] sd_wr_o,

	output logic                                  io_done_o
);

	logic rd_q;
	logic rd_qq;
	logic wr_q;
	logic wr_qq;
	logic ack_q;
	logic ack_qq;
	logic ack_any;
	logic rd_rise;
	logic wr_rise;
	logic ack_fall;

	assign ack_any  = |sd_ack_i;
	assign rd_rise  = rd_q & ~rd_qq;
	assign wr_rise  = wr_q & ~wr_qq;
	assign ack_fall = ack_qq & ~ack_q;

	// ========================================================================
	// Request and completion tracking
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			rd_q      <= 1'b0;
			rd_qq     <= 1'b0;
			wr_q      <= 1'b0;
			wr_qq     <= 1'b0;
			ack_q     <= 1'b0;
			ack_qq    <= 1'b0;
			sd_rd_o   <= '0;
			sd_wr_o   <= '0;
			io_done_o <= 1'b0;
		end else begin
			rd_q   <= blk_rd_i;
			rd_qq  <= rd_q;
			wr_q   <= blk_wr_i;
			wr_qq  <= wr_q;
			ack_q  <= ack_any;
			ack_qq <= ack_q;

			// A new request hides the previous completion
			if (rd_rise) begin
				sd_rd_o[slot_i] <= 1'b1;
				io_done_o       <= 1'b0;
			end
			if (wr_rise) begin
				sd_wr_o[slot_i] <= 1'b1;
				io_done_o       <= 1'b0;
			end

			// Server has taken the request
			if (ack_any) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end

			// Transfer over once the acknowledge drops
			if (ack_fall) begin
				io_done_o <= 1'b1;
			end
		end
	end

	// The image server handles one slot at a time
	req_onehot: assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0(sd_rd_o | sd_wr_o))
		else $error("block_request: more than one request bit set");

	// Host must wait for io_done before the next block
	req_no_overlap: assert property (@(posedge clk_sys) disable iff (areset)
		(rd_rise || wr_rise) |-> !(|(sd_rd_o | sd_wr_o)))
		else $error("block_request: new request while one is pending");

endmodule

`default_nettype wire

// ==== source/disk_bridge_pkg.sv ====
// Shared widths, slot constants and host word layouts; referenced by scoped names
`default_nettype none

package disk_bridge_pkg;

	// ========================================================================
	// Sizes
	// ========================================================================
	localparam int NUM_SLOTS  = 8;
	localparam int SLOT_W     = 3;
	localparam int BUF_ADDR_W = 9;
	localparam int LBA_W      = 32;
	localparam int SIZE_W     = 32;
	localparam int FTYPE_W    = 2;
	localparam int CTRL_W     = 6;
	localparam int STAT_W     = 8;

	// Cartridge and executable loads can never be written back
	localparam logic [NUM_SLOTS-1:0] READONLY_SLOTS = 8'b0011_0000;

	// ========================================================================
	// Host control word
	// ========================================================================
	localparam int CTRL_LBA_SEL  = 0;
	localparam int CTRL_BLK_RD   = 1;
	localparam int CTRL_BLK_WR   = 2;
	localparam int CTRL_SLOT_LSB = 3;

	// Host status word
	localparam int STAT_IO_DONE = 0;
	localparam int STAT_MOUNTED = 1;
	localparam int STAT_FILENO  = 2;
	localparam int STAT_FTYPE   = 5;
	localparam int STAT_RO      = 7;

	// Host write word, either a full LBA or one buffer byte in the low bits
	typedef union packed {
		logic [LBA_W-1:0] lba;
		struct packed {
			logic [LBA_W-9:0] unused;
			logic [7:0]       data;
		} byte_view;
	} host_data_u;

endpackage

`default_nettype wire

// ==== source/disk_bridge_top.sv ====
// Disk block bridge top level joining the host port, SD image server and mount info
`default_nettype none

module disk_bridge_top (
	input  logic                                   clk_sys,
	input  logic                                   areset,

	// Host side
	input  logic [disk_bridge_pkg::CTRL_W-1:0]     host_ctrl_i,
	input  disk_bridge_pkg::host_data_u            host_wdata_i,
	input  logic                                   host_data_wr_i,
	input  logic                                   host_data_rd_i,
	input  logic                                   host_io_wr_i,
	output logic [disk_bridge_pkg::SIZE_W-1:0]     host_rdata_o,
	output logic [disk_bridge_pkg::STAT_W-1:0]     host_status_o,

	// SD side
	output logic [disk_bridge_pkg::NUM_SLOTS-1:0]  sd_rd_o,
	output logic [disk_bridge_pkg::NUM_SLOTS-1:0]  sd_wr_o,
	input  logic [disk_bridge_pkg::NUM_SLOTS-1:0]  sd_ack_i,
	output logic [disk_bridge_pkg::LBA_W-1:0]      sd_lba_o,
	input  logic [disk_bridge_pkg::BUF_ADDR_W-1:0] sd_buff_addr_i,
	input  logic [7:0]                             sd_buff_dout_i,
	input  logic                                   sd_buff_wr_i,
	output logic [7:0]                             sd_buff_din_o,

	// Mount info
	input  logic [disk_bridge_pkg::NUM_SLOTS-1:0]  img_mounted_i,
	input  logic                                   img_readonly_i,
	input  logic [disk_bridge_pkg::SIZE_W-1:0]     img_size_i,
	input  logic [disk_bridge_pkg::FTYPE_W-1:0]    img_type_i
);

	logic                                   blk_rd;
	logic                                   blk_wr;
	logic [disk_bridge_pkg::SLOT_W-1:0]     slot;
	logic [disk_bridge_pkg::BUF_ADDR_W-1:0] hbuf_addr;
	logic [7:0]                             hbuf_wdata;
	logic                                   hbuf_we;
	logic [7:0]                             hbuf_rdata;
	logic                                   io_done;
	logic [disk_bridge_pkg::SLOT_W-1:0]     fileno;
	logic [disk_bridge_pkg::FTYPE_W-1:0]    ftype;
	logic                                   readonly;
	logic                                   mounted;
	logic [disk_bridge_pkg::SIZE_W-1:0]     file_size;

	assign blk_rd = host_ctrl_i[disk_bridge_pkg::CTRL_BLK_RD];
	assign blk_wr = host_ctrl_i[disk_bridge_pkg::CTRL_BLK_WR];
	assign slot   = host_ctrl_i[disk_bridge_pkg::CTRL_SLOT_LSB +: disk_bridge_pkg::SLOT_W];

	// ========================================================================
	// Status word for the host
	// ========================================================================
	always_comb begin
		host_status_o = '0;
		host_status_o[disk_bridge_pkg::STAT_IO_DONE] = io_done;
		host_status_o[disk_bridge_pkg::STAT_MOUNTED] = mounted;
		host_status_o[disk_bridge_pkg::STAT_FILENO +: disk_bridge_pkg::SLOT_W] = fileno;
		host_status_o[disk_bridge_pkg::STAT_FTYPE +: disk_bridge_pkg::FTYPE_W] = ftype;
		host_status_o[disk_bridge_pkg::STAT_RO] = readonly;
	end

	// Port a to the image server, port b to the host
	sector_buffer u_sector_buffer (
		.clk_sys   (clk_sys),
		.a_addr_i  (sd_buff_addr_i),
		.a_wdata_i (sd_buff_dout_i),
		.a_we_i    (sd_buff_wr_i),
		.a_rdata_o (sd_buff_din_o),
		.b_addr_i  (hbuf_addr),
		.b_wdata_i (hbuf_wdata),
		.b_we_i    (hbuf_we),
		.b_rdata_o (hbuf_rdata)
	);

	host_port u_host_port (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.host_ctrl_i    (host_ctrl_i),
		.host_wdata_i   (host_wdata_i),
		.host_data_wr_i (host_data_wr_i),
		.host_data_rd_i (host_data_rd_i),
		.host_io_wr_i   (host_io_wr_i),
		.file_size_i    (file_size),
		.buf_rdata_i    (hbuf_rdata),
		.buf_addr_o     (hbuf_addr),
		.buf_wdata_o    (hbuf_wdata),
		.buf_we_o       (hbuf_we),
		.lba_o          (sd_lba_o),
		.host_rdata_o   (host_rdata_o)
	);

	block_request u_block_request (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.blk_rd_i  (blk_rd),
		.blk_wr_i  (blk_wr),
		.slot_i    (slot),
		.sd_ack_i  (sd_ack_i),
		.sd_rd_o   (sd_rd_o),
		.sd_wr_o   (sd_wr_o),
		.io_done_o (io_done)
	);

	mount_tracker u_mount_tracker (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i),
		.fileno_o       (fileno),
		.ftype_o        (ftype),
		.readonly_o     (readonly),
		.mounted_o      (mounted),
		.file_size_o    (file_size)
	);

endmodule

`default_nettype wire

// ==== source/host_port.sv ====
// Host strobe decoding, sector buffer pointer, LBA register and host read-data mux
`default_nettype none

module host_port (
	input  logic                                   clk_sys,
	input  logic                                   areset,

	input  logic [disk_bridge_pkg::CTRL_W-1:0]     host_ctrl_i,
	input  disk_bridge_pkg::host_data_u            host_wdata_i,
	input  logic                                   host_data_wr_i,
	input  logic                                   host_data_rd_i,
	input  logic                                   host_io_wr_i,

	input  logic [disk_bridge_pkg::SIZE_W-1:0]     file_size_i,

	input  logic [7:0]                             buf_rdata_i,
	output logic [disk_bridge_pkg::BUF_ADDR_W-1:0] buf_addr_o,
	output logic [7:0]                             buf_wdata_o,
	output logic                                   buf_we_o,

	output logic [disk_bridge_pkg::LBA_W-1:0]      lba_o,
	output logic [disk_bridge_pkg::SIZE_W-1:0]     host_rdata_o
);

	logic                                   lba_sel;
	logic                                   wr_q;
	logic                                   wr_qq;
	logic                                   rd_q;
	logic                                   rd_qq;
	logic                                   wr_rise;
	logic                                   rd_fall;
	logic [disk_bridge_pkg::BUF_ADDR_W-1:0] ptr;

	assign lba_sel = host_ctrl_i[disk_bridge_pkg::CTRL_LBA_SEL];

	// Rising write and falling read, both taken from a two-stage history
	assign wr_rise = wr_q & ~wr_qq;
	assign rd_fall = rd_qq & ~rd_q;

	// ========================================================================
	// Strobe history, pointer and LBA
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_q     <= 1'b0;
			wr_qq    <= 1'b0;
			rd_q     <= 1'b0;
			rd_qq    <= 1'b0;
			buf_we_o <= 1'b0;
			ptr      <= '0;
			lba_o    <= '0;
		end else begin
			wr_q     <= host_data_wr_i;
			wr_qq    <= wr_q;
			rd_q     <= host_data_rd_i;
			rd_qq    <= rd_q;
			buf_we_o <= 1'b0;

			// Pointer moves on past the byte just written
			if (buf_we_o) begin
				ptr <= ptr + 1'b1;
			end

			if (wr_rise) begin
				if (lba_sel) begin
					lba_o <= host_wdata_i.lba;
				end else begin
					buf_we_o <= 1'b1;
				end
			end

			if (rd_fall) begin
				ptr <= ptr + 1'b1;
			end

			// I/O strobe restarts the sector transfer at byte 0
			if (host_io_wr_i) begin
				ptr <= '0;
			end
		end
	end

	// Byte to be written is held until the buffer write one cycle later
	always_ff @(posedge clk_sys) begin
		if (wr_rise && !lba_sel) begin
			buf_wdata_o <= host_wdata_i.byte_view.data;
		end
	end

	assign buf_addr_o = ptr;

	// Size in LBA mode, otherwise the buffer byte under the pointer
	assign host_rdata_o = lba_sel ? file_size_i
		: {{(disk_bridge_pkg::SIZE_W - 8){1'b0}}, buf_rdata_i};

	// A buffer write and its pointer step must not meet another pointer move
	we_no_ptr_clash: assert property (@(posedge clk_sys) disable iff (areset)
		buf_we_o |-> !(rd_fall || host_io_wr_i))
		else $error("host_port: buffer write collides with a read or I/O strobe");

endmodule

`default_nettype wire

// ==== source/mount_tracker.sv ====
// Records slot, type, read-only state and size of the latest image mount
`default_nettype none

module mount_tracker (
	input  logic                                  clk_sys,
	input  logic                                  areset,

	input  logic [disk_bridge_pkg::NUM_SLOTS-1:0] img_mounted_i,
	input  logic                                  img_readonly_i,
	input  logic [disk_bridge_pkg::SIZE_W-1:0]    img_size_i,
	input  logic [disk_bridge_pkg::FTYPE_W-1:0]   img_type_i,

	output logic [disk_bridge_pkg::SLOT_W-1:0]    fileno_o,
	output logic [disk_bridge_pkg::FTYPE_W-1:0]   ftype_o,
	output logic                                  readonly_o,
	output logic                                  mounted_o,
	output logic [disk_bridge_pkg::SIZE_W-1:0]    file_size_o
);

	logic [disk_bridge_pkg::NUM_SLOTS-1:0] mounted_q;
	logic                                  any_q;
	logic                                  ro_q;
	logic [disk_bridge_pkg::SIZE_W-1:0]    size_q;
	logic [disk_bridge_pkg::FTYPE_W-1:0]   type_q;
	logic                                  mount_rise;
	logic [disk_bridge_pkg::SLOT_W-1:0]    slot_hi;

	assign mount_rise = (|mounted_q) & ~any_q;

	// Highest slot wins when several bits are set
	always_comb begin
		slot_hi = '0;
		for (int i = 0; i < disk_bridge_pkg::NUM_SLOTS; i++) begin
			if (mounted_q[i]) begin
				slot_hi = disk_bridge_pkg::SLOT_W'(i);
			end
		end
	end

	// ========================================================================
	// Mount detection and toggle
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mounted_q <= '0;
			any_q     <= 1'b0;
			mounted_o <= 1'b0;
		end else begin
			mounted_q <= img_mounted_i;
			any_q     <= |mounted_q;
			if (mount_rise) begin
				mounted_o <= ~mounted_o;
			end
		end
	end

	// Image details staged alongside the mount vector
	always_ff @(posedge clk_sys) begin
		ro_q   <= img_readonly_i;
		size_q <= img_size_i;
		type_q <= img_type_i;
		if (mount_rise) begin
			fileno_o    <= slot_hi;
			ftype_o     <= type_q;
			readonly_o  <= ro_q | disk_bridge_pkg::READONLY_SLOTS[slot_hi];
			file_size_o <= size_q;
		end
	end

endmodule

`default_nettype wire

// ==== source/sector_buffer.sv ====
// Dual-port 512x8 sector RAM; port a serves the SD side, port b the host side
`default_nettype none

module sector_buffer (
	input  logic                                  clk_sys,

	input  logic [disk_bridge_pkg::BUF_ADDR_W-1:0] a_addr_i,
	input  logic [7:0]                            a_wdata_i,
	input  logic                                  a_we_i,
	output logic [7:0]                            a_rdata_o,

	input  logic [disk_bridge_pkg::BUF_ADDR_W-1:0] b_addr_i,
	input  logic [7:0]                            b_wdata_i,
	input  logic                                  b_we_i,
	output logic [7:0]                            b_rdata_o
);

	localparam int DEPTH = 1 << disk_bridge_pkg::BUF_ADDR_W;

	logic [7:0] mem [0:DEPTH-1];

	// Both ports read the old contents on a same-address write
	always_ff @(posedge clk_sys) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_wdata_i;
		end
		if (b_we_i) begin
			mem[b_addr_i] <= b_wdata_i;
		end
		a_rdata_o <= mem[a_addr_i];
		b_rdata_o <= mem[b_addr_i];
	end

	// Write addresses must be resolved whenever a write is requested
	a_addr_known: assert property (@(posedge clk_sys) a_we_i |-> !$isunknown(a_addr_i))
		else $error("sector_buffer: port a write to unknown address");
	b_addr_known: assert property (@(posedge clk_sys) b_we_i |-> !$isunknown(b_addr_i))
		else $error("sector_buffer: port b write to unknown address");

endmodule

`default_nettype wire

// ==== vlog.f ====
source/disk_bridge_pkg.sv
source/sector_buffer.sv
source/host_port.sv
source/block_request.sv
source/mount_tracker.sv
source/disk_bridge_top.sv
dv/tb_disk_bridge.sv
